// File: bench/cpuModel.svh
/*
   Instruction set model of the core, random program generator and LCG
*/
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

   ////////////////////////////////////////
   // Random numbers
   ////////////////////////////////////////
   logic [31:0] rngState = 32'hf834d7bb;

   // Numerical Recipes constants, upper bits are the better ones
   function automatic int unsigned randBelow(input int unsigned n);
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return (rngState >> 16) % n;
   endfunction

   ////////////////////////////////////////
   // Program generator
   ////////////////////////////////////////
   localparam logic [4:0] SET_OPS [3] = '{cpuPkg::SEQ, cpuPkg::SLT, cpuPkg::SLE};
   localparam logic [4:0] IMM_OPS [4] = '{cpuPkg::ADDI, cpuPkg::SUBI, cpuPkg::XORI,
                                          cpuPkg::ANDNI};
   localparam logic [4:0] BR_OPS [4]  = '{cpuPkg::BEQZ, cpuPkg::BNEZ, cpuPkg::BLTZ,
                                          cpuPkg::BGEZ};
   // Opcodes outside the supported set
   localparam logic [4:0] ILL_OPS [6] = '{5'b00010, 5'b00011, 5'b00101, 5'b10000,
                                          5'b10100, 5'b11111};

   // Kind 0 reg-reg, 1 immediate, 2 branch, 3 jump, else any class
   function automatic logic [15:0] randInstr(input int kind);
      int unsigned cls;
      logic [4:0]  op;
      logic [10:0] body;
      body = 11'(randBelow(2048));
      // About a third are byte loads so registers hold varied values
      if (randBelow(10) < 3) begin
         cls = randBelow(2);
      end else begin
         case (kind)
            0:       cls = 2 + randBelow(2);
            1:       cls = 4;
            2:       cls = 5;
            3:       cls = 6;
            default: cls = randBelow(8);
         endcase
      end
      case (cls)
         0: op = cpuPkg::LBI;
         1: op = cpuPkg::SLBI;
         2: op = cpuPkg::ALUR;
         3: op = SET_OPS[randBelow(3)];
         4: op = IMM_OPS[randBelow(4)];
         // Forward by 0 to 3 instructions
         5: begin
            op        = BR_OPS[randBelow(4)];
            body[7:0] = 8'(2 * randBelow(4));
         end
         6: begin
            op   = (randBelow(2) == 0) ? cpuPkg::J : cpuPkg::JAL;
            body = 11'(2 * randBelow(4));
         end
         default: op = cpuPkg::NOP;
      endcase
      return {op, body};
   endfunction

   function automatic logic [15:0] randIllegal();
      logic [4:0] op;
      op = ILL_OPS[randBelow(6)];
      return {op, 11'(randBelow(2048))};
   endfunction

   ////////////////////////////////////////
   // Architectural model
   ////////////////////////////////////////
   logic [15:0] mMem [MEM_LEN];
   logic [15:0] mRegs [8];
   logic [15:0] mPc;
   logic        mHalted;
   logic        mIllegal;

   // Executes the instruction at mPc and returns its expected writeback
   task automatic modelStep(output logic expValid, output logic [2:0] expReg,
                            output logic [15:0] expData);
      logic [15:0] iw;
      logic [4:0]  op;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] s5;
      logic [15:0] z5;
      logic [15:0] s8;
      logic [15:0] link;
      logic [15:0] npc;
      int          idx;
      idx  = int'(mPc[15:1]);
      iw   = (idx < MEM_LEN) ? mMem[idx] : 16'h0000;
      op   = iw[15:11];
      a    = mRegs[iw[10:8]];
      b    = mRegs[iw[7:5]];
      s5   = {{11{iw[4]}}, iw[4:0]};
      z5   = {11'h000, iw[4:0]};
      s8   = {{8{iw[7]}}, iw[7:0]};
      link = mPc + 16'd2;
      npc  = link;
      expValid = 1'b1;
      expReg   = iw[4:2];
      expData  = '0;
      case (op)
         cpuPkg::ALUR: begin
            case (iw[1:0])
               2'd0:    expData = a + b;
               2'd1:    expData = b - a;
               2'd2:    expData = a ^ b;
               default: expData = a & ~b;
            endcase
         end
         cpuPkg::SEQ: expData = {15'b0, a == b};
         cpuPkg::SLT: expData = {15'b0, $signed(a) < $signed(b)};
         cpuPkg::SLE: expData = {15'b0, $signed(a) <= $signed(b)};
         // Destination sits in the rt position
         cpuPkg::ADDI, cpuPkg::SUBI, cpuPkg::XORI, cpuPkg::ANDNI: begin
            expReg = iw[7:5];
            case (op)
               cpuPkg::ADDI: expData = a + s5;
               cpuPkg::SUBI: expData = s5 - a;
               cpuPkg::XORI: expData = a ^ z5;
               default:      expData = a & ~z5;
            endcase
         end
         cpuPkg::LBI, cpuPkg::SLBI: begin
            expReg  = iw[10:8];
            expData = (op == cpuPkg::LBI) ? s8 : {a[7:0], iw[7:0]};
         end
         cpuPkg::BEQZ, cpuPkg::BNEZ, cpuPkg::BLTZ, cpuPkg::BGEZ: begin
            expValid = 1'b0;
            if ((op == cpuPkg::BEQZ && a == 16'h0) || (op == cpuPkg::BNEZ && a != 16'h0) ||
                (op == cpuPkg::BLTZ && a[15]) || (op == cpuPkg::BGEZ && !a[15])) begin
               npc = link + s8;
            end
         end
         cpuPkg::J, cpuPkg::JAL: begin
            expValid = (op == cpuPkg::JAL);
            expReg   = 3'd7;
            expData  = link;
            npc      = link + {{5{iw[10]}}, iw[10:0]};
         end
         cpuPkg::NOP: expValid = 1'b0;
         // HALT or an unsupported opcode stops the core in place
         default: begin
            expValid = 1'b0;
            npc      = mPc;
            mHalted  = 1'b1;
            mIllegal = (op != cpuPkg::HALT);
         end
      endcase
      if (expValid) begin
         mRegs[expReg] = expData;
      end
      mPc = npc;
   endtask

`endif

// File: bench/cpuCoreTb.sv
/*
   Testbench for the core: clock, reset, program load, trace checks
   against the model, watchdog and report
*/
`timescale 1ns/1ps
`default_nettype none
module cpuCoreTb;
   localparam int PROG_LEN    = 48;
   // HALT words past the program cover the longest forward skip
   localparam int FILL_LEN    = 8;
   localparam int MEM_LEN     = PROG_LEN + FILL_LEN;
   localparam int NUM_TESTS   = 5;
   localparam int HOLD_CYCLES = 10;
   localparam int FREEZE_AT   = 10;
   localparam int FREEZE_LEN  = 4;
   localparam int WATCHDOG_NS = NUM_TESTS * (PROG_LEN + 10) * 4 * 10;

   logic         clk;
   logic         arstN;
   logic         run;
   logic         loadEn;
   cpuPkg::wordT loadAddr;
   cpuPkg::wordT loadData;
   cpuPkg::wordT pc;
   cpuPkg::wbT   wb;
   logic         halted;
   logic         illegal;

   int errCount;
   int checkCount;
   int instrCount;
   string testNames [NUM_TESTS] = '{"regReg", "immediate", "branch", "jump", "mixIllegal"};

   `include "cpuModel.svh"

   cpuCore #(
      .IMEM_WORDS (256)
   ) dut_i (
      .clk      (clk),
      .arstN    (arstN),
      .run      (run),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .pc       (pc),
      .wb       (wb),
      .halted   (halted),
      .illegal  (illegal)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Generous bound on the length of all tests
   initial begin
      #WATCHDOG_NS;
      $display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("*** TEST FAILED ***");
      $finish;
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   task automatic checkValue(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
      checkCount++;
      assert (act === exp) else begin
         $display("[ERROR] %s expected %h got %h", name, exp, act);
         errCount++;
      end
   endtask

   // Sampled at the rising edge, before the core updates
   task automatic checkCycle();
      logic        expValid;
      logic [2:0]  expReg;
      logic [15:0] expData;
      checkValue("halted", 16'h0, {15'b0, halted});
      checkValue("illegal", 16'h0, {15'b0, illegal});
      checkValue("pc", mPc, pc);
      if (run) begin
         modelStep(expValid, expReg, expData);
         instrCount++;
         checkValue("wb.valid", {15'b0, expValid}, {15'b0, wb.valid});
         if (expValid) begin
            checkValue("wb.reg", {13'b0, expReg}, {13'b0, wb.regSel});
            checkValue("wb.data", expData, wb.data);
         end
      end else begin
         // Frozen core
         checkValue("wb.valid", 16'h0, {15'b0, wb.valid});
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   task automatic runTest(input int testNum);
      int errStart;
      int cycle;
      errStart   = errCount;
      instrCount = 0;
      for (int i = 0; i < MEM_LEN; i++) begin
         mMem[i] = (i < PROG_LEN) ? randInstr(testNum) : 16'h0000;
      end
      // Four in a row so no forward skip can pass them
      if (testNum == 4) begin
         for (int i = 40; i < 44; i++) begin
            mMem[i] = randIllegal();
         end
      end
      for (int r = 0; r < 8; r++) begin
         mRegs[r] = 16'h0;
      end
      mPc      = 16'h0;
      mHalted  = 1'b0;
      mIllegal = 1'b0;

      @(negedge clk);
      run   = 1'b0;
      arstN = 1'b0;
      repeat (2) @(negedge clk);
      arstN = 1'b1;
      // Program load while the core is idle
      for (int i = 0; i < MEM_LEN; i++) begin
         loadEn   = 1'b1;
         loadAddr = 16'(2 * i);
         loadData = mMem[i];
         @(negedge clk);
      end
      loadEn = 1'b0;

      cycle = 0;
      while (!mHalted) begin
         @(negedge clk);
         run = (cycle < FREEZE_AT) || (cycle >= FREEZE_AT + FREEZE_LEN);
         @(posedge clk);
         checkCycle();
         cycle++;
      end
      // Core must stay stopped with run still high
      repeat (HOLD_CYCLES) begin
         @(posedge clk);
         checkValue("halted", 16'h1, {15'b0, halted});
         checkValue("illegal", {15'b0, mIllegal}, {15'b0, illegal});
         checkValue("pc", mPc, pc);
         checkValue("wb.valid", 16'h0, {15'b0, wb.valid});
      end
      @(negedge clk);
      run = 1'b0;
      $display("Test %0d %s finished after %0d instructions with %0d errors",
               testNum, testNames[testNum], instrCount, errCount - errStart);
   endtask

   initial begin
      arstN      = 1'b0;
      run        = 1'b0;
      loadEn     = 1'b0;
      loadAddr   = '0;
      loadData   = '0;
      errCount   = 0;
      checkCount = 0;
      instrCount = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         runTest(t);
      end
      $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, checkCount, errCount);
      if (errCount == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
`default_nettype wire

// File: build.f
+incdir+bench
logic/cpuPkg.sv
logic/regFile.sv
logic/fetchUnit.sv
logic/decode.sv
logic/execute.sv
logic/cpuCore.sv
bench/cpuCoreTb.sv

// File: logic/cpuCore.sv
/*
   Core top: fetch, decode and execute with load, trace and status ports
*/
`timescale 1ns/1ps
`default_nettype none
module cpuCore #(
   parameter int IMEM_WORDS = 256
) (
   input  logic         clk,
   input  logic         arstN,
   input  logic         run,
   input  logic         loadEn,
   input  cpuPkg::wordT loadAddr,
   input  cpuPkg::wordT loadData,
   output cpuPkg::wordT pc,
   output cpuPkg::wbT   wb,
   output logic         halted,
   output logic         illegal
);
   cpuPkg::instrU instr;
   cpuPkg::wordT  pcInc;
   cpuPkg::wordT  nextPc;
   cpuPkg::decT   dec;
   logic          active;
   logic          stop;
   // Opcode check of the current instruction
   logic          decIllegal;

   fetchUnit #(
      .IMEM_WORDS (IMEM_WORDS)
   ) fetchUnit_i (
      .clk      (clk),
      .arstN    (arstN),
      .run      (run),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .nextPc   (nextPc),
      .stop     (stop),
      .instr    (instr),
      .pc       (pc),
      .pcInc    (pcInc),
      .halted   (halted),
      .illegal  (illegal),
      .active   (active)
   );

   decode decode_i (
      .clk     (clk),
      .arstN   (arstN),
      .instr   (instr),
      .pcInc   (pcInc),
      .wb      (wb),
      .dec     (dec),
      .illegal (decIllegal)
   );

   // Writeback loops back to the register file
   execute execute_i (
      .dec     (dec),
      .active  (active),
      .illegal (decIllegal),
      .nextPc  (nextPc),
      .stop    (stop),
      .wb      (wb)
   );

endmodule
`default_nettype wire

// File: logic/cpuPkg.sv
/*
   Shared types for the 16-bit core: opcodes, instruction formats,
   decode control struct and writeback struct
*/
`default_nettype none
package cpuPkg;

   // 16-bit data word
   typedef logic [15:0] wordT;

   // Any opcode missing here decodes as illegal
   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      J     = 5'b00100,
      JAL   = 5'b00110,
      ADDI  = 5'b01000,
      SUBI  = 5'b01001,
      XORI  = 5'b01010,
      ANDNI = 5'b01011,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      BLTZ  = 5'b01110,
      BGEZ  = 5'b01111,
      SLBI  = 5'b10010,
      LBI   = 5'b11000,
      ALUR  = 5'b11011,
      SEQ   = 5'b11100,
      SLT   = 5'b11101,
      SLE   = 5'b11110
   } opcodeE;

   ////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////
   // Reg-reg format where func picks ADD SUB XOR ANDN
   typedef struct packed {
      opcodeE     op;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } rFmtT;

   // Immediate ALU ops with 5-bit immediate
   typedef struct packed {
      opcodeE     op;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm5;
   } iFmtT;

   // Jump format whose low 8 bits double as the 8-bit immediate
   typedef struct packed {
      opcodeE      op;
      logic [10:0] disp;
   } jFmtT;

   typedef union packed {
      rFmtT r;
      iFmtT i;
      jFmtT j;
   } instrU;

   ////////////////////////////////////////
   // Control and datapath bundles
   ////////////////////////////////////////
   typedef struct packed {
      logic       immSrc;   // 11-bit displacement jump
      logic       aluJmp;   // Conditional branch
      logic       invA;
      logic       invB;
      logic       cin;
      logic [2:0] aluOp;    // 10x add, 110 xor, 111 and
      logic [2:0] brType;   // 1xx branch on zero, 0xx set compare
      logic [1:0] bSrc;     // rt, imm5, imm8, SLBI word
      logic [1:0] regDst;   // rd, rt, rs, r7
      logic [1:0] regSrc;   // ALU, compare, B operand, link PC
      logic       regWrt;
      logic       isSet;
      logic       halt;
   } ctrlT;

   typedef struct packed {
      ctrlT       ctrl;
      wordT       rsData;
      wordT       rtData;
      wordT       imm5;
      wordT       imm8;
      wordT       imm11;
      logic [2:0] wrReg;
      wordT       pcInc;
   } decT;

   typedef struct packed {
      logic       valid;
      logic [2:0] regSel;
      wordT       data;
   } wbT;

endpackage
`default_nettype wire

// File: logic/decode.sv
/*
   Decode stage: opcode to control struct, immediate extends,
   illegal opcode detect and register file
*/
`timescale 1ns/1ps
`default_nettype none
module decode (
   input  logic          clk,
   input  logic          arstN,
   input  cpuPkg::instrU instr,
   input  cpuPkg::wordT  pcInc,
   input  cpuPkg::wbT    wb,
   output cpuPkg::decT   dec,
   output logic          illegal
);
   logic [4:0]   opBits;
   cpuPkg::ctrlT ctrl;
   logic         zext5;
   logic         zext8;
   cpuPkg::wordT rsData;
   cpuPkg::wordT rtData;

   assign opBits = instr.r.op;

   ////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////
   always_comb begin
      ctrl       = '0;
      ctrl.aluOp = 3'b100;
      illegal    = 1'b0;
      case (instr.r.op)
         cpuPkg::HALT: ctrl.halt = 1'b1;
         // Nothing to do
         cpuPkg::NOP: begin
         end
         // Immediate ALU group, low opcode bits pick the op
         cpuPkg::ADDI, cpuPkg::SUBI, cpuPkg::XORI, cpuPkg::ANDNI: begin
            ctrl.aluOp  = {1'b1, opBits[1:0]};
            ctrl.invA   = (opBits[1:0] == 2'b01);
            ctrl.invB   = (opBits[1:0] == 2'b11);
            ctrl.bSrc   = 2'b01;
            ctrl.regDst = 2'b01;
            ctrl.regWrt = 1'b1;
         end
         // Reg-reg group, func field picks the op
         cpuPkg::ALUR: begin
            ctrl.aluOp  = {1'b1, instr.r.func};
            ctrl.invA   = (instr.r.func == 2'b01);
            ctrl.invB   = (instr.r.func == 2'b11);
            ctrl.regWrt = 1'b1;
         end
         // Branches test rs against zero
         cpuPkg::BEQZ, cpuPkg::BNEZ, cpuPkg::BLTZ, cpuPkg::BGEZ: begin
            ctrl.aluJmp = 1'b1;
            ctrl.brType = {1'b1, opBits[1:0]};
            ctrl.bSrc   = 2'b10;
         end
         // Set compares rs with rt
         cpuPkg::SEQ, cpuPkg::SLT, cpuPkg::SLE: begin
            ctrl.isSet  = 1'b1;
            ctrl.brType = {1'b0, opBits[1:0]};
            ctrl.regSrc = 2'b01;
            ctrl.regWrt = 1'b1;
         end
         // Byte loads write rs straight from the B operand
         cpuPkg::LBI, cpuPkg::SLBI: begin
            ctrl.bSrc   = (instr.r.op == cpuPkg::SLBI) ? 2'b11 : 2'b10;
            ctrl.regSrc = 2'b10;
            ctrl.regDst = 2'b10;
            ctrl.regWrt = 1'b1;
         end
         cpuPkg::J: ctrl.immSrc = 1'b1;
         // Link into r7
         cpuPkg::JAL: begin
            ctrl.immSrc = 1'b1;
            ctrl.regSrc = 2'b11;
            ctrl.regDst = 2'b11;
            ctrl.regWrt = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
      // Carry in completes two's complement, AND ignores it
      ctrl.cin = ctrl.invA | ctrl.invB;
   end

   ////////////////////////////////////////
   // Extends and decode bundle
   ////////////////////////////////////////
   // Zero extend for XORI ANDNI and SLBI byte
   assign zext5 = (opBits[4:1] == 4'b0101);
   assign zext8 = (instr.r.op == cpuPkg::SLBI);

   always_comb begin
      dec.ctrl   = ctrl;
      dec.rsData = rsData;
      dec.rtData = rtData;
      dec.imm5   = zext5 ? {11'h000, instr.i.imm5} : {{11{instr.i.imm5[4]}}, instr.i.imm5};
      dec.imm8   = zext8 ? {8'h00, instr.j.disp[7:0]}
                         : {{8{instr.j.disp[7]}}, instr.j.disp[7:0]};
      // Jump displacement always signed
      dec.imm11  = {{5{instr.j.disp[10]}}, instr.j.disp};
      dec.pcInc  = pcInc;
      case (ctrl.regDst)
         2'b00:   dec.wrReg = instr.r.rd;
         2'b01:   dec.wrReg = instr.i.rd;
         2'b10:   dec.wrReg = instr.r.rs;
         default: dec.wrReg = 3'd7;
      endcase
   end

   regFile regFile_i (
      .clk       (clk),
      .arstN     (arstN),
      .read1Sel  (instr.r.rs),
      .read2Sel  (instr.r.rt),
      .wb        (wb),
      .read1Data (rsData),
      .read2Data (rtData)
   );

endmodule
`default_nettype wire

// File: logic/execute.sv
/*
   Execute stage: ALU, set and branch compare, next PC select,
   writeback data select
*/
`timescale 1ns/1ps
`default_nettype none
module execute (
   input  cpuPkg::decT  dec,
   input  logic         active,
   input  logic         illegal,
   output cpuPkg::wordT nextPc,
   output logic         stop,
   output cpuPkg::wbT   wb
);
   cpuPkg::wordT bOper;
   cpuPkg::wordT aIn;
   cpuPkg::wordT bIn;
   cpuPkg::wordT sum;
   cpuPkg::wordT aluRes;
   cpuPkg::wordT cmpB;
   cpuPkg::wordT target;
   logic         cond;
   logic         taken;

   ////////////////////////////////////////
   // ALU
   ////////////////////////////////////////
   // B operand source
   always_comb begin
      case (dec.ctrl.bSrc)
         2'b00:   bOper = dec.rtData;
         2'b01:   bOper = dec.imm5;
         2'b10:   bOper = dec.imm8;
         // SLBI shifts rs up and fills the low byte
         default: bOper = (dec.rsData << 8) | dec.imm8;
      endcase
   end

   // SUB is B + ~A + 1
   assign aIn = dec.rsData ^ {16{dec.ctrl.invA}};
   assign bIn = bOper ^ {16{dec.ctrl.invB}};
   assign sum = aIn + bIn + {15'b0, dec.ctrl.cin};

   always_comb begin
      case (dec.ctrl.aluOp)
         3'b110:  aluRes = aIn ^ bIn;
         // ANDN sees B already inverted
         3'b111:  aluRes = aIn & bIn;
         default: aluRes = sum;
      endcase
   end

   ////////////////////////////////////////
   // Compare for sets and branches
   ////////////////////////////////////////
   // Branches compare against zero
   assign cmpB = dec.ctrl.isSet ? dec.rtData : '0;

   always_comb begin
      case (dec.ctrl.brType)
         3'b000, 3'b100: cond = (dec.rsData == cmpB);
         3'b101:         cond = (dec.rsData != cmpB);
         3'b001, 3'b110: cond = ($signed(dec.rsData) < $signed(cmpB));
         3'b010:         cond = ($signed(dec.rsData) <= $signed(cmpB));
         3'b111:         cond = ($signed(dec.rsData) >= $signed(cmpB));
         default:        cond = 1'b0;
      endcase
   end

   // Jumps always taken, branches on condition
   assign taken  = dec.ctrl.immSrc | (dec.ctrl.aluJmp & cond);
   assign target = dec.pcInc + (dec.ctrl.immSrc ? dec.imm11 : dec.imm8);
   assign nextPc = taken ? target : dec.pcInc;
   assign stop   = dec.ctrl.halt | illegal;

   ////////////////////////////////////////
   // Writeback
   ////////////////////////////////////////
   assign wb.valid  = dec.ctrl.regWrt & active & ~illegal;
   assign wb.regSel = dec.wrReg;

   always_comb begin
      case (dec.ctrl.regSrc)
         2'b00:   wb.data = aluRes;
         2'b01:   wb.data = {15'b0, cond};
         2'b10:   wb.data = bOper;
         // Link is PC+2
         default: wb.data = dec.pcInc;
      endcase
   end

endmodule
`default_nettype wire

// File: logic/fetchUnit.sv
/*
   Fetch stage: program counter, instruction memory with load port,
   halt and illegal status
*/
`timescale 1ns/1ps
`default_nettype none
module fetchUnit #(
   parameter int IMEM_WORDS = 256
) (
   input  logic          clk,
   input  logic          arstN,
   input  logic          run,
   input  logic          loadEn,
   input  cpuPkg::wordT  loadAddr,
   input  cpuPkg::wordT  loadData,
   input  cpuPkg::wordT  nextPc,
   input  logic          stop,
   output cpuPkg::instrU instr,
   output cpuPkg::wordT  pc,
   output cpuPkg::wordT  pcInc,
   output logic          halted,
   output logic          illegal,
   output logic          active
);
   // Word index width, addresses are byte based
   localparam int AW = $clog2(IMEM_WORDS);

   cpuPkg::wordT imem [IMEM_WORDS];

   // Loaded by the testbench while the core is idle
   always_ff @(posedge clk) begin
      if (loadEn) begin
         imem[loadAddr[AW:1]] <= loadData;
      end
   end

   // Combinational instruction read
   assign instr  = imem[pc[AW:1]];
   assign pcInc  = pc + 16'd2;
   assign active = run & ~halted;

   // PC holds on the stopping instruction
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc      <= '0;
         halted  <= 1'b0;
         illegal <= 1'b0;
      end else if (active) begin
         if (stop) begin
            halted  <= 1'b1;
            // Stop without a HALT opcode means decode flagged it
            illegal <= (instr.r.op != cpuPkg::HALT);
         end else begin
            pc <= nextPc;
         end
      end
   end

endmodule
`default_nettype wire

// File: logic/regFile.sv
/*
   Eight 16-bit registers, two async read ports, one write port
*/
`timescale 1ns/1ps
`default_nettype none
module regFile (
   input  logic         clk,
   input  logic         arstN,
   input  logic [2:0]   read1Sel,
   input  logic [2:0]   read2Sel,
   input  cpuPkg::wbT   wb,
   output cpuPkg::wordT read1Data,
   output cpuPkg::wordT read2Data
);
   cpuPkg::wordT regs [8];

   // Write at the edge that ends the instruction
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.regSel] <= wb.data;
      end
   end

   // No bypass, a write shows up next cycle
   assign read1Data = regs[read1Sel];
   assign read2Data = regs[read2Sel];

endmodule
`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module cpuCoreTb

out=$(./obj_dir/VcpuCoreTb)
echo "$out"

# Fails the script when the pass line is missing
echo "$out" | grep -qF '*** TEST PASSED ***'
